//--- Bender.yml
package:
  name: core_pipe

sources:
  - files:
      - logic/core_pkg.sv
      - logic/fetch_unit.sv
      - logic/reg_file.sv
      - logic/decode_issue.sv
      - logic/execute_unit.sv
      - logic/bus_arbiter.sv
      - logic/core_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/apb_mem_model.sv
      - testbench/core_chk.sv
      - testbench/core_tb.sv

//--- filelist.f
logic/core_pkg.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/decode_issue.sv
logic/execute_unit.sv
logic/bus_arbiter.sv
logic/core_top.sv
testbench/tb_clock.sv
testbench/apb_mem_model.sv
testbench/core_chk.sv
testbench/core_tb.sv

//--- logic/bus_arbiter.sv
module bus_arbiter #(
   parameter int addr_width = 16
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  fetch_req,
   input  logic [addr_width-1:0] fetch_addr,
   output logic                  fetch_done,
   input  logic                  data_req,
   input  logic [addr_width-1:0] data_addr,
   input  logic                  data_we,
   input  core_pkg::word_t       data_wdata,
   output logic                  data_done,
   output core_pkg::word_t       rdata,
   output logic [addr_width-1:0] paddr,
   output logic                  psel,
   output logic                  penable,
   output logic                  pwrite,
   output core_pkg::word_t       pwdata,
   input  core_pkg::word_t       prdata,
   input  logic                  pready
);
   import core_pkg::*;

   typedef enum logic [1:0] {idle, setup, access} state_e;

   state_e state;
   logic   owner_data;
   logic   xfer_end;

   assign psel    = (state != idle);
   assign penable = (state == access);

   // done goes back in the cycle pready is seen
   assign xfer_end   = (state == access) && pready;
   assign fetch_done = xfer_end && !owner_data;
   assign data_done  = xfer_end && owner_data;
   assign rdata      = prdata;

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= idle;
         owner_data <= 1'b0;
         pwrite     <= 1'b0;
      end else begin
         case (state)
            idle: begin
               // data side wins
               if (data_req) begin
                  state      <= setup;
                  owner_data <= 1'b1;
                  pwrite     <= data_we;
               end else if (fetch_req) begin
                  state      <= setup;
                  owner_data <= 1'b0;
                  pwrite     <= 1'b0;
               end
            end
            setup: state <= access;
            access: begin
               if (pready) begin
                  state <= idle;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   // address and write data held for the whole transfer
   always_ff @(posedge clk) begin
      if (state == idle) begin
         paddr  <= data_req ? data_addr : fetch_addr;
         pwdata <= data_wdata;
      end
   end

endmodule

//--- logic/core_pkg.sv
package core_pkg;

   // field widths of the 32-bit instruction word
   localparam int word_width    = 32;
   localparam int op_width      = 4;
   localparam int reg_idx_width = 3;
   localparam int imm_width     = 16;

   localparam int num_regs = 8;

   // field positions, counted from the top bit down
   localparam int op_msb = word_width - 1;
   localparam int rd_msb = op_msb - op_width;
   localparam int ra_msb = rd_msb - reg_idx_width;
   localparam int rb_msb = ra_msb - reg_idx_width;

   typedef logic [word_width-1:0]    word_t;
   typedef logic [reg_idx_width-1:0] reg_idx_t;
   typedef logic [imm_width-1:0]     imm_t;

   typedef enum logic [op_width-1:0] {
      op_nop  = 4'd0,
      op_add  = 4'd1,
      op_sub  = 4'd2,
      op_and  = 4'd3,
      op_or   = 4'd4,
      op_xor  = 4'd5,
      op_movi = 4'd6,
      op_ld   = 4'd7,
      op_st   = 4'd8,
      op_xchg = 4'd9,
      op_halt = 4'd10
   } op_e;

endpackage

//--- logic/core_top.sv
module core_top #(
   parameter int addr_width = 16,
   parameter int unsigned reset_pc = 0
) (
   input  logic                  clk,
   input  logic                  rst,
   output logic [addr_width-1:0] paddr,
   output logic                  psel,
   output logic                  penable,
   output logic                  pwrite,
   output core_pkg::word_t       pwdata,
   input  core_pkg::word_t       prdata,
   input  logic                  pready,
   output logic                  halted
);
   import core_pkg::*;

   // fetch side
   logic                  fetch_req;
   logic [addr_width-1:0] fetch_addr;
   logic                  fetch_done;
   logic                  fetch_valid;
   word_t                 fetch_instr;
   logic                  fetch_ready;
   word_t                 rdata;

   // register read
   reg_idx_t              rd_idx_a;
   reg_idx_t              rd_idx_b;
   word_t                 rd_data_a;
   word_t                 rd_data_b;

   // issue to execute
   logic                  issue_valid;
   op_e                   issue_op;
   reg_idx_t              issue_rd;
   reg_idx_t              issue_ra;
   word_t                 issue_a;
   word_t                 issue_b;
   imm_t                  issue_imm;
   logic                  issue_ready;

   // data side and writeback
   logic                  data_req;
   logic [addr_width-1:0] data_addr;
   logic                  data_we;
   word_t                 data_wdata;
   logic                  data_done;
   logic                  wb_en;
   reg_idx_t              wb_idx;
   word_t                 wb_data;
   logic                  wb_en2;
   reg_idx_t              wb_idx2;
   word_t                 wb_data2;

   fetch_unit #(.addr_width(addr_width), .reset_pc(reset_pc)) fetch_unit_i (.*);

   decode_issue decode_issue_i (.*);

   reg_file reg_file_i (.*);

   execute_unit #(.addr_width(addr_width)) execute_unit_i (.*);

   bus_arbiter #(.addr_width(addr_width)) bus_arbiter_i (.*);

endmodule

//--- logic/decode_issue.sv
module decode_issue (
   input  logic               clk,
   input  logic               rst,
   input  logic               fetch_valid,
   input  core_pkg::word_t    fetch_instr,
   output logic               fetch_ready,
   output core_pkg::reg_idx_t rd_idx_a,
   output core_pkg::reg_idx_t rd_idx_b,
   input  core_pkg::word_t    rd_data_a,
   input  core_pkg::word_t    rd_data_b,
   output logic               issue_valid,
   output core_pkg::op_e      issue_op,
   output core_pkg::reg_idx_t issue_rd,
   output core_pkg::reg_idx_t issue_ra,
   output core_pkg::word_t    issue_a,
   output core_pkg::word_t    issue_b,
   output core_pkg::imm_t     issue_imm,
   input  logic               issue_ready,
   input  logic               wb_en,
   input  core_pkg::reg_idx_t wb_idx,
   input  logic               wb_en2,
   input  core_pkg::reg_idx_t wb_idx2,
   output logic               halted
);
   import core_pkg::*;

   logic                d_valid;
   word_t               d_instr;
   op_e                 op;
   reg_idx_t            rd_f;
   reg_idx_t            ra_f;
   reg_idx_t            rb_f;
   logic [num_regs-1:0] busy;
   logic [num_regs-1:0] busy_set;
   logic [num_regs-1:0] busy_clr;
   logic                is_alu;
   logic                uses_ra;
   logic                uses_rb;
   logic                writes_rd;
   logic                stall;
   logic                fire;

   // field split of the head instruction
   assign op   = op_e'(d_instr[op_msb -: op_width]);
   assign rd_f = d_instr[rd_msb -: reg_idx_width];
   assign ra_f = d_instr[ra_msb -: reg_idx_width];
   assign rb_f = d_instr[rb_msb -: reg_idx_width];

   assign is_alu    = (op == op_add) || (op == op_sub) || (op == op_and) ||
                      (op == op_or) || (op == op_xor);
   assign uses_ra   = is_alu || (op == op_ld) || (op == op_st) || (op == op_xchg);
   assign uses_rb   = is_alu || (op == op_st);
   assign writes_rd = is_alu || (op == op_movi) || (op == op_ld) || (op == op_xchg);

   // xchg needs the old rd on the b port
   assign rd_idx_a = ra_f;
   assign rd_idx_b = (op == op_xchg) ? rd_f : rb_f;

   assign stall = (uses_ra && busy[ra_f]) || (uses_rb && busy[rb_f]) ||
                  (writes_rd && busy[rd_f]);

   assign issue_valid = d_valid && (op != op_halt) && !stall;
   assign issue_op    = op;
   assign issue_rd    = rd_f;
   assign issue_ra    = ra_f;
   assign issue_a     = rd_data_a;
   assign issue_b     = rd_data_b;
   assign issue_imm   = d_instr[imm_width-1:0];

   assign fire        = issue_valid && issue_ready;
   // halt parks at the head, so the queue stops draining
   assign fetch_ready = !d_valid || fire;

   // scoreboard update
   always_comb begin
      busy_set = '0;
      busy_clr = '0;
      if (fire && writes_rd) begin
         busy_set[rd_f] = 1'b1;
      end
      if (fire && (op == op_xchg)) begin
         busy_set[ra_f] = 1'b1;
      end
      if (wb_en) begin
         busy_clr[wb_idx] = 1'b1;
      end
      if (wb_en2) begin
         busy_clr[wb_idx2] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         d_valid <= 1'b0;
         busy    <= '0;
         halted  <= 1'b0;
      end else begin
         if (fetch_ready) begin
            d_valid <= fetch_valid;
         end
         busy <= (busy & ~busy_clr) | busy_set;
         if (d_valid && (op == op_halt) && (busy == '0) && issue_ready) begin
            halted <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_ready && fetch_valid) begin
         d_instr <= fetch_instr;
      end
   end

endmodule

//--- logic/execute_unit.sv
module execute_unit #(
   parameter int addr_width = 16
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  issue_valid,
   input  core_pkg::op_e         issue_op,
   input  core_pkg::reg_idx_t    issue_rd,
   input  core_pkg::reg_idx_t    issue_ra,
   input  core_pkg::word_t       issue_a,
   input  core_pkg::word_t       issue_b,
   input  core_pkg::imm_t        issue_imm,
   output logic                  issue_ready,
   output logic                  data_req,
   output logic [addr_width-1:0] data_addr,
   output logic                  data_we,
   output core_pkg::word_t       data_wdata,
   input  logic                  data_done,
   input  core_pkg::word_t       rdata,
   output logic                  wb_en,
   output core_pkg::reg_idx_t    wb_idx,
   output core_pkg::word_t       wb_data,
   output logic                  wb_en2,
   output core_pkg::reg_idx_t    wb_idx2,
   output core_pkg::word_t       wb_data2
);
   import core_pkg::*;

   typedef enum logic [1:0] {idle, alu_wb, mem_wait} state_e;

   state_e state;
   logic   accept;
   logic   is_mem;
   logic   writes_rd;
   word_t  imm_ext;
   word_t  eff_addr;
   word_t  alu_res;

   assign issue_ready = (state == idle);
   assign accept      = issue_valid && issue_ready;
   assign data_req    = (state == mem_wait);

   assign is_mem    = (issue_op == op_ld) || (issue_op == op_st);
   assign writes_rd = (issue_op inside {op_add, op_sub, op_and, op_or, op_xor,
                                        op_movi, op_xchg});
   assign imm_ext   = word_t'(issue_imm);
   assign eff_addr  = issue_a + imm_ext;

   always_comb begin
      case (issue_op)
         op_add:  alu_res = issue_a + issue_b;
         op_sub:  alu_res = issue_a - issue_b;
         op_and:  alu_res = issue_a & issue_b;
         op_or:   alu_res = issue_a | issue_b;
         op_xor:  alu_res = issue_a ^ issue_b;
         op_movi: alu_res = imm_ext;
         default: alu_res = issue_a;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= idle;
         wb_en  <= 1'b0;
         wb_en2 <= 1'b0;
      end else begin
         wb_en  <= 1'b0;
         wb_en2 <= 1'b0;
         case (state)
            idle: begin
               if (accept && is_mem) begin
                  state <= mem_wait;
               end else if (accept) begin
                  state  <= alu_wb;
                  wb_en  <= writes_rd;
                  // old rd lands in ra
                  wb_en2 <= (issue_op == op_xchg) && (issue_ra != issue_rd);
               end
            end
            mem_wait: begin
               if (data_done) begin
                  state <= alu_wb;
                  wb_en <= !data_we;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   // operand and result registers
   always_ff @(posedge clk) begin
      if (accept) begin
         wb_idx     <= issue_rd;
         wb_data    <= alu_res;
         wb_idx2    <= issue_ra;
         wb_data2   <= issue_b;
         data_addr  <= eff_addr[addr_width-1:0];
         data_we    <= (issue_op == op_st);
         data_wdata <= issue_b;
      end else if ((state == mem_wait) && data_done) begin
         wb_data <= rdata;
      end
   end

endmodule

//--- logic/fetch_unit.sv
module fetch_unit #(
   parameter int addr_width = 16,
   parameter int unsigned reset_pc = 0
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  halted,
   output logic                  fetch_req,
   output logic [addr_width-1:0] fetch_addr,
   input  logic                  fetch_done,
   input  core_pkg::word_t       rdata,
   output logic                  fetch_valid,
   output core_pkg::word_t       fetch_instr,
   input  logic                  fetch_ready
);
   import core_pkg::*;

   logic [addr_width-1:0] pc;
   word_t                 queue [2];
   logic                  wr_ptr;
   logic                  rd_ptr;
   logic [1:0]            count;
   logic                  halt_seen;
   logic                  push;
   logic                  pop;

   // one fetch outstanding at most, held until the arbiter answers
   // nothing past a fetched halt word is requested
   assign fetch_req  = !halted && !halt_seen && (count != 2'd2);
   assign fetch_addr = pc;

   assign push = fetch_done;
   assign pop  = fetch_valid && fetch_ready;

   assign fetch_valid = (count != 2'd0);
   assign fetch_instr = queue[rd_ptr];

   always_ff @(posedge clk) begin
      if (rst) begin
         pc        <= addr_width'(reset_pc);
         wr_ptr    <= 1'b0;
         rd_ptr    <= 1'b0;
         count     <= 2'd0;
         halt_seen <= 1'b0;
      end else begin
         if (push) begin
            pc     <= pc + addr_width'(4);
            wr_ptr <= ~wr_ptr;
            if (op_e'(rdata[op_msb -: op_width]) == op_halt) begin
               halt_seen <= 1'b1;
            end
         end
         if (pop) begin
            rd_ptr <= ~rd_ptr;
         end
         count <= count + 2'(push) - 2'(pop);
      end
   end

   // queue storage
   always_ff @(posedge clk) begin
      if (push) begin
         queue[wr_ptr] <= rdata;
      end
   end

endmodule

//--- logic/reg_file.sv
module reg_file (
   input  logic               clk,
   input  logic               rst,
   input  core_pkg::reg_idx_t rd_idx_a,
   input  core_pkg::reg_idx_t rd_idx_b,
   output core_pkg::word_t    rd_data_a,
   output core_pkg::word_t    rd_data_b,
   input  logic               wb_en,
   input  core_pkg::reg_idx_t wb_idx,
   input  core_pkg::word_t    wb_data,
   input  logic               wb_en2,
   input  core_pkg::reg_idx_t wb_idx2,
   input  core_pkg::word_t    wb_data2
);
   import core_pkg::*;

   word_t regs [num_regs];

   assign rd_data_a = regs[rd_idx_a];
   assign rd_data_b = regs[rd_idx_b];

   // second port only used by xchg, never the same index as the first
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (wb_en) begin
            regs[wb_idx] <= wb_data;
         end
         if (wb_en2) begin
            regs[wb_idx2] <= wb_data2;
         end
      end
   end

endmodule

//--- testbench/apb_mem_model.sv
module apb_mem_model #(
   parameter int addr_width = 16,
   parameter logic [31:0] seed = 32'd81055
) (
   input  logic                  clk,
   input  logic                  wait_en,
   input  logic [addr_width-1:0] paddr,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  core_pkg::word_t       pwdata,
   output core_pkg::word_t       prdata,
   output logic                  pready
);
   import core_pkg::*;

   localparam int depth = 2 ** (addr_width - 2);

   word_t       mem [depth];
   logic [31:0] lfsr = seed;
   logic [31:0] lfsr_next;

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   assign lfsr_next = lfsr_step(lfsr);

   initial begin
      prdata = '0;
      pready = 1'b0;
   end

   always @(posedge clk) begin
      if (psel && penable && pready && pwrite) begin
         mem[paddr[addr_width-1:2]] <= pwdata;
      end
      prdata <= mem[paddr[addr_width-1:2]];
      // one lfsr step per wait-state decision
      if (wait_en) begin
         lfsr   <= lfsr_next;
         pready <= lfsr_next[0];
      end else begin
         pready <= 1'b1;
      end
   end

endmodule

//--- testbench/core_chk.sv
module core_chk #(
   parameter int addr_width = 16
) (
   input logic                  clk,
   input logic                  rst,
   input logic [addr_width-1:0] paddr,
   input logic                  psel,
   input logic                  penable,
   input logic                  pwrite,
   input logic [31:0]           pwdata,
   input logic                  pready,
   input logic                  halted
);

   // failed assertions so far
   int fail_count = 0;

   // access phase only right after a setup phase
   penable_after_setup: assert property (@(posedge clk) disable iff (rst)
      $rose(penable) |-> $past($rose(psel)))
      else begin
         $error("penable rose without a setup cycle before it");
         fail_count++;
      end

   // transfer fields held until the slave answers
   fields_held: assert property (@(posedge clk) disable iff (rst)
      (psel && !(penable && pready)) |=>
         ($stable(paddr) && $stable(pwrite) && $stable(pwdata)))
      else begin
         $error("paddr, pwrite or pwdata changed during a transfer");
         fail_count++;
      end

   quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
      halted |-> !psel)
      else begin
         $error("psel high while the core is halted");
         fail_count++;
      end

endmodule

bind core_top core_chk #(.addr_width(addr_width)) core_chk_i (
   .clk     (clk),
   .rst     (rst),
   .paddr   (paddr),
   .psel    (psel),
   .penable (penable),
   .pwrite  (pwrite),
   .pwdata  (pwdata),
   .pready  (pready),
   .halted  (halted)
);

//--- testbench/core_tb.sv
module core_tb;
   import core_pkg::*;

   localparam int clk_period       = 100;
   localparam int addr_width       = 16;
   localparam int cycles_per_instr = 12;
   localparam int max_tests        = 16;
   localparam int max_words        = 256;
   localparam int max_exp          = 64;
   localparam logic [31:0] lfsr_seed = 32'd81055;

   logic                  clk;
   logic                  rst = 1'b1;
   logic                  wait_en = 1'b0;
   logic [addr_width-1:0] paddr;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   word_t                 pwdata;
   word_t                 prdata;
   logic                  pready;
   logic                  halted;

   // parsed test table
   string       names [max_tests];
   int          wait_flag [max_tests];
   int          prog_first [max_tests];
   int          prog_len [max_tests];
   int          exp_first [max_tests];
   int          exp_len [max_tests];
   word_t       prog_words [max_words];
   logic [31:0] exp_addr [max_exp];
   word_t       exp_data [max_exp];
   int          num_tests = 0;
   int          num_words = 0;
   int          num_exp = 0;

   bit tests_ok;
   int failed_tests = 0;
   int cycles = 0;
   int cycle_limit = 0;

   tb_clock #(.period(clk_period)) clock_i (.clk(clk));

   apb_mem_model #(.addr_width(addr_width), .seed(lfsr_seed)) mem_model_i (.*);

   core_top #(.addr_width(addr_width), .reset_pc(0)) core_top_i (.*);

   task automatic load_tests(output bit ok);
      int    fd;
      int    rc;
      int    mode;
      int    total;
      string tok;
      string line;
      word_t v;
      word_t a;
      ok = 1'b0;
      fd = $fopen("testbench/core_tests.txt", "r");
      if (fd != 0) begin
         ok = 1'b1;
         // mode 1 takes program words, mode 2 takes address and data pairs
         mode = 0;
         rc = $fscanf(fd, "%s", tok);
         while (rc == 1) begin
            if (tok.substr(0, 0) == "#") begin
               rc = $fgets(line, fd);
            end else if (tok == "test" || tok == "again") begin
               rc = $fscanf(fd, "%s %d", names[num_tests], wait_flag[num_tests]);
               if (tok == "again" && num_tests > 0) begin
                  prog_first[num_tests] = prog_first[num_tests-1];
                  prog_len[num_tests]   = prog_len[num_tests-1];
                  exp_first[num_tests]  = exp_first[num_tests-1];
                  exp_len[num_tests]    = exp_len[num_tests-1];
               end else begin
                  prog_first[num_tests] = num_words;
                  prog_len[num_tests]   = 0;
                  exp_first[num_tests]  = num_exp;
                  exp_len[num_tests]    = 0;
               end
               num_tests++;
               mode = 0;
            end else if (tok == "prog") begin
               mode = 1;
            end else if (tok == "expect") begin
               mode = 2;
            end else if (mode == 1 && num_tests > 0) begin
               rc = $sscanf(tok, "%h", v);
               prog_words[num_words] = v;
               num_words++;
               prog_len[num_tests-1]++;
            end else if (mode == 2 && num_tests > 0) begin
               rc = $sscanf(tok, "%h", a);
               rc = $fscanf(fd, "%h", v);
               exp_addr[num_exp] = a;
               exp_data[num_exp] = v;
               num_exp++;
               exp_len[num_tests-1]++;
            end else begin
               ok = 1'b0;
            end
            rc = $fscanf(fd, "%s", tok);
         end
         $fclose(fd);
         total = 0;
         for (int t = 0; t < num_tests; t++) begin
            total += prog_len[t];
         end
         cycle_limit = total * cycles_per_instr;
         if (num_tests == 0) begin
            ok = 1'b0;
         end
      end
   endtask

   task automatic load_memory(input int t);
      // background pattern differs at every word address
      for (int i = 0; i < 2 ** (addr_width - 2); i++) begin
         mem_model_i.mem[i] = {~16'(i), 16'(i)};
      end
      for (int k = 0; k < prog_len[t]; k++) begin
         mem_model_i.mem[k] = prog_words[prog_first[t] + k];
      end
   endtask

   task automatic run_test(input int t);
      int    errs;
      int    idx;
      int    chk_start;
      word_t got;
      errs = 0;
      chk_start = core_top_i.core_chk_i.fail_count;
      @(posedge clk);
      rst     <= 1'b1;
      wait_en <= wait_flag[t][0];
      load_memory(t);
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      @(negedge clk);
      while (!halted) @(negedge clk);

      // bus must stay quiet once halted
      repeat (4) begin
         @(negedge clk);
         assert (psel == 1'b0) else begin
            $display("APB transfer started after halted in test %0s", names[t]);
            errs++;
         end
      end

      for (int i = 0; i < exp_len[t]; i++) begin
         idx = exp_first[t] + i;
         got = mem_model_i.mem[exp_addr[idx][addr_width-1:2]];
         assert (got == exp_data[idx]) else begin
            $display("Error: time %0t, mem[0x%h] expected %h, got %h",
                     $time, exp_addr[idx][addr_width-1:0], exp_data[idx], got);
            errs++;
         end
      end

      // protocol assertions bound into the DUT
      assert (core_top_i.core_chk_i.fail_count == chk_start) else begin
         $display("APB protocol assertions failed %0d times in test %0s",
                  core_top_i.core_chk_i.fail_count - chk_start, names[t]);
         errs += core_top_i.core_chk_i.fail_count - chk_start;
      end

      if (errs == 0) begin
         $display("test %0s (wait states %0d): passed", names[t], wait_flag[t]);
      end else begin
         $display("test %0s (wait states %0d): failed with %0d errors",
                  names[t], wait_flag[t], errs);
         failed_tests++;
      end
   endtask

   // watchdog over the whole run
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout: tests did not finish within %0d cycles", cycle_limit);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   initial begin
      load_tests(tests_ok);
      if (!tests_ok) begin
         $display("could not read a valid test table from testbench/core_tests.txt");
         $display("STATUS: FAIL");
         $finish;
      end else begin
         for (int t = 0; t < num_tests; t++) begin
            run_test(t);
         end
         $display("tests run %0d, passed %0d, failed %0d",
                  num_tests, num_tests - failed_tests, failed_tests);
         if (failed_tests == 0) begin
            $display("STATUS: PASS");
         end else begin
            $display("STATUS: FAIL");
         end
         $finish;
      end
   end

endmodule

//--- testbench/core_tests.txt
# test <name> <wait states 0/1>, then prog <instruction words>, expect <byte addr> <word> pairs
# again <name> <wait states 0/1> reruns the previous test's program and expected words
test alu 0
prog 620000F0 64000F0F 28080000 17100000 3B100000 5D100000 4E680000
     80180100 80200104 80280108 8030010C 80380110 A0000000
expect 0100 00000E1F 0104 FFFFFF10 0108 00000F00 010C FFFFF01F 0110 00000FF0
again alu_wait 1
test ldst 0
prog 62000200 64001357 26100000 80580008 68000100 7B000108 80280300 1D500000
     80300304 A0000000
expect 0208 FFFFECA9 0300 FFFFECA9 0304 00000000
again ldst_wait 1
test xchg 0
prog 6200AAAA 64005555 92800000 80080100 80100104 A0000000
expect 0100 00005555 0104 0000AAAA
again xchg_wait 1
test dep 0
prog 62000001 14480000 16900000 16D80000 28C80000 98C00000 5B180000 80280100
     80200104 A0000000
expect 0100 0000000F 0104 00000008
again dep_wait 1

//--- testbench/tb_clock.sv
module tb_clock #(
   parameter int period = 100
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

endmodule
